// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= execBackendTb
FILELIST  ?= all.f

SOURCES := $(wildcard logic/*.sv) $(wildcard tests/*.sv)
SIMBIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIMBIN)
	@out="$$(./$(SIMBIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== all.f ====
logic/backendCfgPkg.sv
logic/opcodePkg.sv
logic/aluLane.sv
logic/csrUnit.sv
logic/issueDispatch.sv
logic/writeBack.sv
logic/execBackend.sv
tests/clockGen.sv
tests/wbChecker.sv
tests/writeBack_asserts.sv
tests/execBackendTb.sv

// ==== logic/aluLane.sv ====
module aluLane (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                laneValid,
    input  opcodePkg::aluOp                     laneOp,
    input  logic [backendCfgPkg::robIdxW-1:0]   laneRobIdx,
    input  logic [backendCfgPkg::regIdxW-1:0]   laneRd,
    input  logic [backendCfgPkg::xlen-1:0]      laneSrc1,
    input  logic [backendCfgPkg::xlen-1:0]      laneSrc2,
    input  backendCfgPkg::excCode               laneExc,
    output logic                                resEn,
    output logic                                resWe,
    output logic [backendCfgPkg::robIdxW-1:0]   resRobIdx,
    output logic [backendCfgPkg::regIdxW-1:0]   resRd,
    output logic [backendCfgPkg::xlen-1:0]      resVal,
    output backendCfgPkg::excCode               resExc
);
    import backendCfgPkg::*;
    import opcodePkg::*;

    logic [shamtW-1:0] shamt;
    logic [xlen-1:0] aluOut;
    logic sltOut;
    logic sltuOut;

    assign shamt = laneSrc2[shamtW-1:0];
    assign sltOut = $signed(laneSrc1) < $signed(laneSrc2);
    assign sltuOut = laneSrc1 < laneSrc2;

    always_comb begin
        case (laneOp)
            opAdd:   aluOut = laneSrc1 + laneSrc2;
            opSub:   aluOut = laneSrc1 - laneSrc2;
            opAnd:   aluOut = laneSrc1 & laneSrc2;
            opOr:    aluOut = laneSrc1 | laneSrc2;
            opXor:   aluOut = laneSrc1 ^ laneSrc2;
            opSll:   aluOut = laneSrc1 << shamt;
            opSrl:   aluOut = laneSrc1 >> shamt;
            opSra:   aluOut = $unsigned($signed(laneSrc1) >>> shamt);
            opSlt:   aluOut = {{(xlen-1){1'b0}}, sltOut};
            opSltu:  aluOut = {{(xlen-1){1'b0}}, sltuOut};
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resEn <= 1'b0;
            resWe <= 1'b0;
        end else begin
            resEn <= laneValid;
            resWe <= laneValid && laneExc == excNone && laneRd != '0;   // x0 is never written
        end
    end

    always_ff @(posedge clk) begin
        resRobIdx <= laneRobIdx;
        resRd <= laneRd;
        resVal <= (laneExc == excNone) ? aluOut : '0;
        resExc <= laneExc;
    end

endmodule

// ==== logic/backendCfgPkg.sv ====
package backendCfgPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // backend sizing

    localparam int aluLanes = 4;
    localparam int wbSlots = aluLanes + 1;     // lanes plus the load slot at the top
    localparam int xlen = 32;
    localparam int shamtW = $clog2(xlen);      // shift amount comes from the low src2 bits
    localparam int robIdxW = 6;
    localparam int regIdxW = 5;
    localparam int immW = 12;                  // wide enough for a CSR address

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // exception codes carried to the write-back bus

    typedef enum logic [1:0] {
        excNone    = 2'd0,
        excIllegal = 2'd1,                     // undefined opcode or CSR op off lane 0
        excCsrAddr = 2'd2                      // CSR address not implemented
    } excCode;

endpackage

// ==== logic/csrUnit.sv ====
module csrUnit (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                csrValid,
    input  opcodePkg::csrOp                     csrKind,
    input  logic [opcodePkg::csrAddrW-1:0]      csrAddr,
    input  logic [backendCfgPkg::xlen-1:0]      csrSrc,
    input  logic [backendCfgPkg::robIdxW-1:0]   csrRobIdx,
    input  logic [backendCfgPkg::regIdxW-1:0]   csrRd,
    output logic                                csrResEn,
    output logic                                csrResWe,
    output logic [backendCfgPkg::robIdxW-1:0]   csrResRobIdx,
    output logic [backendCfgPkg::regIdxW-1:0]   csrResRd,
    output logic [backendCfgPkg::xlen-1:0]      csrResVal,
    output backendCfgPkg::excCode               csrResExc
);
    import backendCfgPkg::*;
    import opcodePkg::*;

    // state names shadow the op literals, so ops below use scoped names where they clash
    typedef enum logic [1:0] {csrIdle, csrRead, csrWrite} csrState;

    csrState state;
    csrOp reqKind;
    excCode reqExc;
    logic [xlen-1:0] scratch, cycleCnt, oldVal, reqSrc, newVal;
    logic [robIdxW-1:0] reqRobIdx;
    logic [regIdxW-1:0] reqRd;
    logic addrScratch, addrCycle;

    assign addrScratch = csrAddr == csrScratch;
    assign addrCycle = csrAddr == csrCycle;

    always_comb begin
        case (reqKind)
            opcodePkg::csrWrite: newVal = reqSrc;
            csrSet:              newVal = oldVal | reqSrc;
            csrClear:            newVal = oldVal & ~reqSrc;
            default:             newVal = oldVal;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= csrIdle;
            csrResEn <= 1'b0;
            csrResWe <= 1'b0;
            scratch <= '0;
            cycleCnt <= '0;
        end else begin
            cycleCnt <= cycleCnt + xlen'(1);
            csrResEn <= state != csrIdle;
            csrResWe <= state != csrIdle && reqExc == excNone && reqRd != '0;
            if (state == csrWrite)
                scratch <= newVal;                      // second step applies the update
            if (csrValid && addrScratch && csrKind != opcodePkg::csrRead)
                state <= csrWrite;
            else if (csrValid)
                state <= csrRead;                       // cycle counter and bad addresses only read
            else
                state <= csrIdle;
        end
    end

    always_ff @(posedge clk) begin
        if (csrValid) begin
            reqKind <= csrKind;
            reqSrc <= csrSrc;
            reqRobIdx <= csrRobIdx;
            reqRd <= csrRd;
            reqExc <= (addrScratch || addrCycle) ? excNone : excCsrAddr;
            oldVal <= addrScratch ? scratch : (addrCycle ? cycleCnt : '0);
        end
        csrResRobIdx <= reqRobIdx;
        csrResRd <= reqRd;
        csrResVal <= oldVal;
        csrResExc <= reqExc;
    end

endmodule

// ==== logic/execBackend.sv ====
module execBackend (
    input  logic                                                        clk,
    input  logic                                                        rstN,
    input  logic [backendCfgPkg::aluLanes-1:0]                          issueValid,
    input  logic [backendCfgPkg::aluLanes-1:0][opcodePkg::opW-1:0]      issueOp,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::robIdxW-1:0] issueRobIdx,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::regIdxW-1:0] issueRd,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::xlen-1:0] issueSrc1,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::xlen-1:0] issueSrc2,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::immW-1:0] issueImm,
    input  logic                                                        loadValid,
    input  logic [backendCfgPkg::robIdxW-1:0]                           loadRobIdx,
    input  logic [backendCfgPkg::regIdxW-1:0]                           loadRd,
    input  logic [backendCfgPkg::xlen-1:0]                              loadData,
    input  backendCfgPkg::excCode                                       loadExc,
    output logic [backendCfgPkg::wbSlots-1:0]                           wbEn,
    output logic [backendCfgPkg::wbSlots-1:0]                           wbWe,
    output logic [backendCfgPkg::wbSlots-1:0][backendCfgPkg::robIdxW-1:0] wbRobIdx,
    output logic [backendCfgPkg::wbSlots-1:0][backendCfgPkg::regIdxW-1:0] wbRd,
    output logic [backendCfgPkg::wbSlots-1:0][backendCfgPkg::xlen-1:0]  wbRes,
    output backendCfgPkg::excCode [backendCfgPkg::wbSlots-1:0]          wbExc
);
    import backendCfgPkg::*;
    import opcodePkg::*;

    logic [aluLanes-1:0] laneValid, resEn, resWe;
    aluOp [aluLanes-1:0] laneOp;
    logic [aluLanes-1:0][robIdxW-1:0] laneRobIdx, resRobIdx;
    logic [aluLanes-1:0][regIdxW-1:0] laneRd, resRd;
    logic [aluLanes-1:0][xlen-1:0] laneSrc1, laneSrc2, resVal;
    excCode [aluLanes-1:0] laneExc, resExc;
    logic csrValid, csrResEn, csrResWe;
    csrOp csrKind;
    logic [csrAddrW-1:0] csrAddr;
    logic [xlen-1:0] csrSrc, csrResVal;
    logic [robIdxW-1:0] csrRobIdx, csrResRobIdx;
    logic [regIdxW-1:0] csrRd, csrResRd;
    excCode csrResExc;

    issueDispatch u_dispatch (.*);

    for (genvar i = 0; i < aluLanes; i++) begin : gLane
        aluLane u_lane (
            .clk(clk), .rstN(rstN),
            .laneValid(laneValid[i]), .laneOp(laneOp[i]), .laneRobIdx(laneRobIdx[i]),
            .laneRd(laneRd[i]), .laneSrc1(laneSrc1[i]), .laneSrc2(laneSrc2[i]),
            .laneExc(laneExc[i]),
            .resEn(resEn[i]), .resWe(resWe[i]), .resRobIdx(resRobIdx[i]),
            .resRd(resRd[i]), .resVal(resVal[i]), .resExc(resExc[i])
        );
    end

    csrUnit u_csr (.*);

    writeBack u_wb (.*);

endmodule

// ==== logic/issueDispatch.sv ====
module issueDispatch (
    input  logic                                                        clk,
    input  logic                                                        rstN,
    input  logic [backendCfgPkg::aluLanes-1:0]                          issueValid,
    input  logic [backendCfgPkg::aluLanes-1:0][opcodePkg::opW-1:0]      issueOp,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::robIdxW-1:0] issueRobIdx,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::regIdxW-1:0] issueRd,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::xlen-1:0] issueSrc1,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::xlen-1:0] issueSrc2,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::immW-1:0] issueImm,
    output logic [backendCfgPkg::aluLanes-1:0]                          laneValid,
    output opcodePkg::aluOp [backendCfgPkg::aluLanes-1:0]               laneOp,
    output logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::robIdxW-1:0] laneRobIdx,
    output logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::regIdxW-1:0] laneRd,
    output logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::xlen-1:0] laneSrc1,
    output logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::xlen-1:0] laneSrc2,
    output backendCfgPkg::excCode [backendCfgPkg::aluLanes-1:0]         laneExc,
    output logic                                                        csrValid,
    output opcodePkg::csrOp                                             csrKind,
    output logic [opcodePkg::csrAddrW-1:0]                              csrAddr,
    output logic [backendCfgPkg::xlen-1:0]                              csrSrc,
    output logic [backendCfgPkg::robIdxW-1:0]                           csrRobIdx,
    output logic [backendCfgPkg::regIdxW-1:0]                           csrRd
);
    import backendCfgPkg::*;
    import opcodePkg::*;

    logic [aluLanes-1:0] isAlu;
    logic [aluLanes-1:0] isCsr;
    logic [aluLanes-1:0] laneTake;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode

    always_comb begin
        for (int i = 0; i < aluLanes; i++) begin
            isAlu[i] = issueOp[i] <= opW'(opSltu);
            isCsr[i] = issueOp[i] >= opW'(csrRead);
            laneTake[i] = issueValid[i];                // illegal ops still travel the lane
        end
        laneTake[0] = issueValid[0] && !isCsr[0];       // lane 0 CSR ops leave for the CSR unit
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            laneValid <= '0;
            csrValid <= 1'b0;
        end else begin
            laneValid <= laneTake;
            csrValid <= issueValid[0] && isCsr[0];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue payload

    always_ff @(posedge clk) begin
        for (int i = 0; i < aluLanes; i++) begin
            laneOp[i] <= isAlu[i] ? aluOp'(issueOp[i]) : opAdd;
            laneExc[i] <= isAlu[i] ? excNone : excIllegal;
            laneRobIdx[i] <= issueRobIdx[i];
            laneRd[i] <= issueRd[i];
            laneSrc1[i] <= issueSrc1[i];
            laneSrc2[i] <= issueSrc2[i];
        end
        csrKind <= csrOp'(issueOp[0]);
        csrAddr <= issueImm[0];                         // the immediate only matters as a CSR address
        csrSrc <= issueSrc1[0];
        csrRobIdx <= issueRobIdx[0];
        csrRd <= issueRd[0];
    end

endmodule

// ==== logic/opcodePkg.sv ====
package opcodePkg;

    localparam int opW = 4;
    localparam int csrAddrW = 12;

    // raw codes 0 to 9, the decoder casts straight from the issue opcode
    typedef enum logic [opW-1:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opXor  = 4'd4,
        opSll  = 4'd5,
        opSrl  = 4'd6,
        opSra  = 4'd7,
        opSlt  = 4'd8,
        opSltu = 4'd9
    } aluOp;

    // 10 and 11 are left undefined
    typedef enum logic [opW-1:0] {
        csrRead  = 4'd12,
        csrWrite = 4'd13,
        csrSet   = 4'd14,
        csrClear = 4'd15
    } csrOp;

    localparam logic [csrAddrW-1:0] csrScratch = 12'h340;
    localparam logic [csrAddrW-1:0] csrCycle = 12'hC00;

endpackage

// ==== logic/writeBack.sv ====
module writeBack (
    input  logic                                                        clk,
    input  logic                                                        rstN,
    input  logic [backendCfgPkg::aluLanes-1:0]                          resEn,
    input  logic [backendCfgPkg::aluLanes-1:0]                          resWe,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::robIdxW-1:0] resRobIdx,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::regIdxW-1:0] resRd,
    input  logic [backendCfgPkg::aluLanes-1:0][backendCfgPkg::xlen-1:0] resVal,
    input  backendCfgPkg::excCode [backendCfgPkg::aluLanes-1:0]         resExc,
    input  logic                                                        csrResEn,
    input  logic                                                        csrResWe,
    input  logic [backendCfgPkg::robIdxW-1:0]                           csrResRobIdx,
    input  logic [backendCfgPkg::regIdxW-1:0]                           csrResRd,
    input  logic [backendCfgPkg::xlen-1:0]                              csrResVal,
    input  backendCfgPkg::excCode                                       csrResExc,
    input  logic                                                        loadValid,
    input  logic [backendCfgPkg::robIdxW-1:0]                           loadRobIdx,
    input  logic [backendCfgPkg::regIdxW-1:0]                           loadRd,
    input  logic [backendCfgPkg::xlen-1:0]                              loadData,
    input  backendCfgPkg::excCode                                       loadExc,
    output logic [backendCfgPkg::wbSlots-1:0]                           wbEn,
    output logic [backendCfgPkg::wbSlots-1:0]                           wbWe,
    output logic [backendCfgPkg::wbSlots-1:0][backendCfgPkg::robIdxW-1:0] wbRobIdx,
    output logic [backendCfgPkg::wbSlots-1:0][backendCfgPkg::regIdxW-1:0] wbRd,
    output logic [backendCfgPkg::wbSlots-1:0][backendCfgPkg::xlen-1:0]  wbRes,
    output backendCfgPkg::excCode [backendCfgPkg::wbSlots-1:0]          wbExc
);
    import backendCfgPkg::*;

    logic [aluLanes-1:0] enQ, weQ;
    logic [aluLanes-1:0][robIdxW-1:0] robIdxQ;
    logic [aluLanes-1:0][regIdxW-1:0] rdQ;
    logic [aluLanes-1:0][xlen-1:0] valQ;
    excCode [aluLanes-1:0] excQ;
    logic csrEnQ, csrWeQ;
    logic [robIdxW-1:0] csrRobIdxQ;
    logic [regIdxW-1:0] csrRdQ;
    logic [xlen-1:0] csrValQ;
    excCode csrExcQ;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            enQ <= '0;
            weQ <= '0;
            csrEnQ <= 1'b0;
            csrWeQ <= 1'b0;
        end else begin
            enQ <= resEn;
            weQ <= resWe;
            csrEnQ <= csrResEn;
            csrWeQ <= csrResWe;
        end
    end

    always_ff @(posedge clk) begin
        robIdxQ <= resRobIdx;
        rdQ <= resRd;
        valQ <= resVal;
        excQ <= resExc;
        csrRobIdxQ <= csrResRobIdx;
        csrRdQ <= csrResRd;
        csrValQ <= csrResVal;
        csrExcQ <= csrResExc;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus slots

    for (genvar i = 0; i < aluLanes; i++) begin : gSlot
        if (i == 0) begin : gMerge
            assign wbEn[i] = csrEnQ | enQ[i];
            assign wbWe[i] = csrEnQ ? csrWeQ : weQ[i];              // CSR wins a shared cycle
            assign wbRobIdx[i] = csrEnQ ? csrRobIdxQ : robIdxQ[i];
            assign wbRd[i] = csrEnQ ? csrRdQ : rdQ[i];
            assign wbRes[i] = csrEnQ ? csrValQ : valQ[i];
            assign wbExc[i] = csrEnQ ? csrExcQ : excQ[i];
        end else begin : gPlain
            assign wbEn[i] = enQ[i];
            assign wbWe[i] = weQ[i];
            assign wbRobIdx[i] = robIdxQ[i];
            assign wbRd[i] = rdQ[i];
            assign wbRes[i] = valQ[i];
            assign wbExc[i] = excQ[i];
        end
    end

    // the load slot is already timed by the memory side
    assign wbEn[aluLanes] = loadValid;
    assign wbWe[aluLanes] = loadValid && loadRd != '0;
    assign wbRobIdx[aluLanes] = loadRobIdx;
    assign wbRd[aluLanes] = loadRd;
    assign wbRes[aluLanes] = loadData;
    assign wbExc[aluLanes] = loadExc;

endmodule

// ==== tests/clockGen.sv ====
module clockGen (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// ==== tests/execBackendTb.sv ====
module execBackendTb;
    timeunit 1ns;
    timeprecision 1ps;
    import backendCfgPkg::*;
    import opcodePkg::*;

    localparam int randCycles = 16;
    localparam int aluLat = 3;
    localparam int csrLat = 4;
    localparam int loadLat = 0;

    logic clk, rstN;
    logic [aluLanes-1:0] issueValid;
    logic [aluLanes-1:0][opW-1:0] issueOp;
    logic [aluLanes-1:0][robIdxW-1:0] issueRobIdx;
    logic [aluLanes-1:0][regIdxW-1:0] issueRd;
    logic [aluLanes-1:0][xlen-1:0] issueSrc1, issueSrc2;
    logic [aluLanes-1:0][immW-1:0] issueImm;
    logic loadValid;
    logic [robIdxW-1:0] loadRobIdx;
    logic [regIdxW-1:0] loadRd;
    logic [xlen-1:0] loadData;
    excCode loadExc;
    logic [wbSlots-1:0] wbEn, wbWe;
    logic [wbSlots-1:0][robIdxW-1:0] wbRobIdx;
    logic [wbSlots-1:0][regIdxW-1:0] wbRd;
    logic [wbSlots-1:0][xlen-1:0] wbRes;
    excCode [wbSlots-1:0] wbExc;

    // stimulus table, lane aluLanes stands for the load port
    int rowLane[$];
    logic [opW-1:0] rowOp[$];
    logic [xlen-1:0] rowSrc1[$], rowSrc2[$], rowRes[$];
    logic [immW-1:0] rowImm[$];
    logic [regIdxW-1:0] rowRd[$];
    logic [robIdxW-1:0] rowRob[$];
    excCode rowExc[$];
    logic rowCyc[$];
    logic [robIdxW-1:0] robCnt = 6'd40;

    clockGen u_clk (.clk(clk), .rstN(rstN));

    execBackend i_dut (.*);

    wbChecker u_check (.*);

    task automatic addRow(input int lane, input logic [opW-1:0] op, input logic [xlen-1:0] s1,
                          input logic [xlen-1:0] s2, input logic [immW-1:0] imm,
                          input logic [regIdxW-1:0] rd, input logic [robIdxW-1:0] rob,
                          input logic [xlen-1:0] res, input excCode exc, input logic cyc);
        rowLane.push_back(lane);
        rowOp.push_back(op);
        rowSrc1.push_back(s1);
        rowSrc2.push_back(s2);
        rowImm.push_back(imm);
        rowRd.push_back(rd);
        rowRob.push_back(rob);
        rowRes.push_back(res);
        rowExc.push_back(exc);
        rowCyc.push_back(cyc);
    endtask

    task automatic fillTable();
        addRow(0, opAdd, 32'd5, 32'd7, 12'h0, 5'd1, 6'd1, 32'd12, excNone, 1'b0);
        addRow(1, opSub, 32'd5, 32'd7, 12'h0, 5'd2, 6'd2, 32'hFFFF_FFFE, excNone, 1'b0);
        addRow(2, opAnd, 32'hF0F0, 32'hFF00, 12'h0, 5'd3, 6'd3, 32'hF000, excNone, 1'b0);
        addRow(3, opOr, 32'hF0F0, 32'h0F0F, 12'h0, 5'd4, 6'd4, 32'hFFFF, excNone, 1'b0);
        addRow(0, opXor, 32'hAAAA, 32'hFFFF, 12'h0, 5'd5, 6'd5, 32'h5555, excNone, 1'b0);
        addRow(1, opSll, 32'd1, 32'd33, 12'h0, 5'd6, 6'd6, 32'd2, excNone, 1'b0);
        addRow(2, opSrl, 32'h8000_0000, 32'd4, 12'h0, 5'd7, 6'd7, 32'h0800_0000, excNone, 1'b0);
        addRow(3, opSra, 32'h8000_0000, 32'd4, 12'h0, 5'd8, 6'd8, 32'hF800_0000, excNone, 1'b0);
        addRow(0, opSlt, 32'hFFFF_FFFF, 32'd1, 12'h0, 5'd9, 6'd9, 32'd1, excNone, 1'b0);
        addRow(1, opSltu, 32'hFFFF_FFFF, 32'd1, 12'h0, 5'd10, 6'd10, 32'd0, excNone, 1'b0);
        addRow(2, opAdd, 32'd3, 32'd4, 12'h0, 5'd0, 6'd11, 32'd7, excNone, 1'b0);
        addRow(0, 4'd10, 32'd1, 32'd2, 12'h0, 5'd12, 6'd12, 32'd0, excIllegal, 1'b0);
        addRow(3, 4'd11, 32'd1, 32'd2, 12'h0, 5'd13, 6'd13, 32'd0, excIllegal, 1'b0);
        addRow(2, csrRead, 32'd1, 32'd0, csrScratch, 5'd14, 6'd14, 32'd0, excIllegal, 1'b0);
        // scratch sequence, each CSR returns the value before its own update
        addRow(0, csrWrite, 32'h1234_5678, 32'd0, csrScratch, 5'd15, 6'd15, 32'd0, excNone, 1'b0);
        addRow(1, opAdd, 32'd1, 32'd1, 12'h0, 5'd16, 6'd16, 32'd2, excNone, 1'b0);
        addRow(0, csrSet, 32'hFF, 32'd0, csrScratch, 5'd17, 6'd17, 32'h1234_5678, excNone, 1'b0);
        addRow(0, csrClear, 32'hF, 32'd0, csrScratch, 5'd18, 6'd18, 32'h1234_56FF, excNone, 1'b0);
        addRow(0, csrRead, 32'd0, 32'd0, csrScratch, 5'd19, 6'd19, 32'h1234_56F0, excNone, 1'b0);
        addRow(0, csrRead, 32'd0, 32'd0, csrCycle, 5'd20, 6'd20, 32'd0, excNone, 1'b1);
        addRow(aluLanes, 4'd0, 32'hDEAD_BEEF, 32'd0, 12'h0, 5'd7, 6'd21, 32'hDEAD_BEEF, excNone, 1'b0);
        addRow(aluLanes, 4'd0, 32'h0BAD_F00D, 32'd0, 12'h0, 5'd0, 6'd22, 32'h0BAD_F00D, excNone, 1'b0);
        addRow(0, csrWrite, 32'd0, 32'd0, csrCycle, 5'd23, 6'd23, 32'd0, excNone, 1'b1);
        addRow(0, csrRead, 32'd0, 32'd0, 12'h123, 5'd24, 6'd24, 32'd0, excCsrAddr, 1'b0);
        addRow(3, opXor, 32'd9, 32'd9, 12'h0, 5'd25, 6'd25, 32'd0, excNone, 1'b0);
        addRow(0, csrRead, 32'd0, 32'd0, csrCycle, 5'd26, 6'd26, 32'd0, excNone, 1'b1);
    endtask

    task automatic clearInputs();
        issueValid = '0;
        issueOp = '0;
        issueRobIdx = '0;
        issueRd = '0;
        issueSrc1 = '0;
        issueSrc2 = '0;
        issueImm = '0;
        loadValid = 1'b0;
        loadRobIdx = '0;
        loadRd = '0;
        loadData = '0;
        loadExc = excNone;
    endtask

    task automatic applyRow(input int k);
        int lane;
        int lat;
        logic we;
        lane = rowLane[k];
        if (lane == aluLanes) begin
            loadValid = 1'b1;
            loadRobIdx = rowRob[k];
            loadRd = rowRd[k];
            loadData = rowSrc1[k];
            loadExc = rowExc[k];
            we = rowRd[k] != '0;
            lat = loadLat;
        end else begin
            issueValid[lane] = 1'b1;
            issueOp[lane] = rowOp[k];
            issueRobIdx[lane] = rowRob[k];
            issueRd[lane] = rowRd[k];
            issueSrc1[lane] = rowSrc1[k];
            issueSrc2[lane] = rowSrc2[k];
            issueImm[lane] = rowImm[k];
            we = rowExc[k] == excNone && rowRd[k] != '0;
            lat = (lane == 0 && rowOp[k] >= opW'(csrRead)) ? csrLat : aluLat;
        end
        u_check.expectResult(lane, rowRob[k], rowRd[k], rowRes[k], rowExc[k], we, rowCyc[k],
                             lat);
    endtask

    // every lane busy with random operands while the load port is also in use
    task automatic randomCycle();
        aluOp op;
        logic [xlen-1:0] a, b;
        logic [regIdxW-1:0] rd;
        for (int l = 0; l < aluLanes; l++) begin
            op = aluOp'(opW'($urandom_range(9)));
            a = $urandom;
            b = $urandom;
            rd = regIdxW'($urandom_range(31));
            issueValid[l] = 1'b1;
            issueOp[l] = op;
            issueRobIdx[l] = robCnt;
            issueRd[l] = rd;
            issueSrc1[l] = a;
            issueSrc2[l] = b;
            u_check.expectResult(l, robCnt, rd, u_check.aluRef(op, a, b), excNone, rd != '0,
                                 1'b0, aluLat);
            robCnt++;
        end
        loadValid = 1'b1;
        loadRobIdx = robCnt;
        loadRd = regIdxW'($urandom_range(31));
        loadData = $urandom;
        u_check.expectResult(aluLanes, robCnt, loadRd, loadData, excNone, loadRd != '0, 1'b0,
                             loadLat);
        robCnt++;
    endtask

    initial begin
        int limit;
        #1;
        limit = (rowLane.size() + randCycles) * 10 + 100;
        repeat (limit) @(posedge clk);
        $display("watchdog timeout, results still outstanding after %0d cycles", limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h65a));
        clearInputs();
        fillTable();
        wait (rstN);
        for (int k = 0; k < rowLane.size(); k++) begin
            @(negedge clk);
            clearInputs();
            applyRow(k);
            if (rowLane[k] == 0 && rowOp[k] >= opW'(csrRead)) begin
                @(negedge clk);
                clearInputs();                          // lane 0 rests after a CSR op
            end
        end
        for (int c = 0; c < randCycles; c++) begin
            @(negedge clk);
            clearInputs();
            randomCycle();
        end
        @(negedge clk);
        clearInputs();
        while (u_check.pendingCount() != 0) @(posedge clk);
        repeat (4) @(posedge clk);                      // idle bus must stay quiet
        u_check.finalReport();
        if (u_check.errCount == 0 && i_dut.u_wb.u_asserts.failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tests/wbChecker.sv ====
module wbChecker (
    input  logic                                                        clk,
    input  logic                                                        rstN,
    input  logic [backendCfgPkg::wbSlots-1:0]                           wbEn,
    input  logic [backendCfgPkg::wbSlots-1:0]                           wbWe,
    input  logic [backendCfgPkg::wbSlots-1:0][backendCfgPkg::robIdxW-1:0] wbRobIdx,
    input  logic [backendCfgPkg::wbSlots-1:0][backendCfgPkg::regIdxW-1:0] wbRd,
    input  logic [backendCfgPkg::wbSlots-1:0][backendCfgPkg::xlen-1:0]  wbRes,
    input  backendCfgPkg::excCode [backendCfgPkg::wbSlots-1:0]          wbExc
);
    timeunit 1ns;
    timeprecision 1ps;
    import backendCfgPkg::*;
    import opcodePkg::*;

    // entry layout is {cycle flag, we, exc, robIdx, rd, result}
    localparam int rdLo = xlen;
    localparam int robLo = rdLo + regIdxW;
    localparam int excLo = robLo + robIdxW;
    localparam int weBit = excLo + 2;
    localparam int cycBit = weBit + 1;
    localparam int entryW = cycBit + 1;

    logic [entryW-1:0] pendQ [wbSlots][$];
    int dueQ [wbSlots][$];
    int edgeCnt = 0;
    logic [xlen-1:0] lastCycle = '0;
    int passCount = 0;
    int errCount = 0;

    // RV32 integer semantics, shifts take the low five bits of b
    function automatic logic [xlen-1:0] aluRef(input aluOp op, input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
        logic [2*xlen-1:0] ext;
        ext = {{xlen{a[xlen-1]}}, a} >> b[4:0];
        case (op)
            opAdd:  return a + b;
            opSub:  return a + ~b + 1;
            opAnd:  return a & b;
            opOr:   return a | b;
            opXor:  return a ^ b;
            opSll:  return a << b[4:0];
            opSrl:  return a >> b[4:0];
            opSra:  return ext[xlen-1:0];
            opSlt:  return (a[xlen-1] != b[xlen-1]) ? xlen'(a[xlen-1]) : xlen'(a < b);
            default: return xlen'(a < b);
        endcase
    endfunction

    task automatic expectResult(input int slot, input logic [robIdxW-1:0] rob,
                                input logic [regIdxW-1:0] rd, input logic [xlen-1:0] res,
                                input excCode exc, input logic we, input logic cyc,
                                input int lat);
        pendQ[slot].push_back({cyc, we, exc, rob, rd, res});
        dueQ[slot].push_back(edgeCnt + 1 + lat);        // the next edge samples the issue
    endtask

    function automatic int pendingCount();
        int n;
        n = 0;
        for (int s = 0; s < wbSlots; s++) n += pendQ[s].size();
        return n;
    endfunction

    task automatic checkSlot(input int s);
        int hit;
        int due;
        logic [entryW-1:0] e;
        logic bad;
        string got;
        hit = -1;
        for (int i = 0; i < pendQ[s].size(); i++) begin
            if (pendQ[s][i][robLo +: robIdxW] == wbRobIdx[s]) hit = i;
        end
        if (hit < 0) begin
            errCount++;
            $display("slot %0d wrote back robIdx %0d at %0t with nothing outstanding",
                     s, wbRobIdx[s], $time);
            return;
        end
        e = pendQ[s][hit];
        due = dueQ[s][hit];
        pendQ[s].delete(hit);
        dueQ[s].delete(hit);
        bad = wbRd[s] != e[rdLo +: regIdxW] || wbWe[s] != e[weBit] ||
              wbExc[s] != e[excLo +: 2] || edgeCnt != due;
        if (e[cycBit]) begin
            bad = bad || wbRes[s] == '0 || wbRes[s] <= lastCycle;   // counter must move on
            lastCycle = wbRes[s];
        end else begin
            bad = bad || wbRes[s] != e[xlen-1:0];
        end
        if (bad) begin
            errCount++;
            got = $sformatf("slot %0d rob %0d got rd %0d we %b exc %0d res %h edge %0d",
                            s, wbRobIdx[s], wbRd[s], wbWe[s], wbExc[s], wbRes[s], edgeCnt);
            $display("** Error @ %0t: %s, want rd %0d we %b exc %0d res %h edge %0d",
                     $time, got, e[rdLo +: regIdxW], e[weBit], e[excLo +: 2], e[xlen-1:0],
                     due);
        end else begin
            passCount++;
            $display("slot %0d rob %0d res %h ok", s, wbRobIdx[s], wbRes[s]);
        end
    endtask

    always @(posedge clk) begin
        edgeCnt++;
        if (rstN) begin
            for (int s = 0; s < wbSlots; s++) begin
                if (wbEn[s]) checkSlot(s);
            end
        end
    end

    task automatic finalReport();
        for (int s = 0; s < wbSlots; s++) begin
            for (int i = 0; i < pendQ[s].size(); i++) begin
                errCount++;
                $display("result for robIdx %0d in slot %0d never arrived",
                         pendQ[s][i][robLo +: robIdxW], s);
            end
        end
        $display("results checked %0d, passed %0d, errors %0d",
                 passCount + errCount, passCount, errCount);
    endtask

endmodule

// ==== tests/writeBack_asserts.sv ====
module writeBackAsserts (
    input logic                               clk,
    input logic                               rstN,
    input logic [backendCfgPkg::aluLanes-1:0] enQ,
    input logic                               csrEnQ,
    input logic [backendCfgPkg::wbSlots-1:0]  wbEn,
    input logic [backendCfgPkg::wbSlots-1:0]  wbWe
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    slotCollision: assert property (@(posedge clk) disable iff (!rstN) !(csrEnQ && enQ[0]))
        else begin
            failCount++;
            $error("CSR and lane 0 results share slot 0");
        end

    resetClears: assert property (@(posedge clk) !rstN |=> wbEn == '0)
        else begin
            failCount++;
            $error("write-back enable set right after reset");
        end

    weNeedsEn: assert property (@(posedge clk) disable iff (!rstN) (wbWe & ~wbEn) == '0)
        else begin
            failCount++;
            $error("write enable without a valid slot");
        end

endmodule

bind writeBack writeBackAsserts u_asserts (.*);
